//--- src/mrdo_video_pkg.sv
`default_nettype none

package mrdo_video_pkg;

    typedef logic [15:0] dl_addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [9:0]  map_addr_t;
    typedef logic [11:0] bitmap_addr_t;
    typedef logic [4:0]  pal_addr_t;
    typedef logic [1:0]  pix_t;
    typedef logic [3:0]  chan_t;
    typedef logic [7:0]  coord_t;

    typedef enum logic {
        LAYER_BG = 1'b0,
        LAYER_FG = 1'b1
    } layer_e;

    // position within an 8 pixel tile group
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_BITMAP,
        FETCH_LOAD
    } fetch_state_e;

    // download address map
    localparam dl_addr_t MAP_BASE    = 16'h0000;
    localparam dl_addr_t PLANE_BASE  = 16'h8000;
    localparam dl_addr_t PAL_HI_BASE = 16'hE000;
    localparam dl_addr_t PAL_LO_BASE = 16'hE020;
    localparam dl_addr_t SCROLL_BASE = 16'hF000;

    // playfield geometry fixed by the board
    localparam int LINE_W   = 256;
    localparam int MAP_COLS = 32;

    // pixel enables from raster counter to the colour outputs
    localparam int PIXEL_LEAD = 2;

    // resistor ladder levels, shared by all three guns
    localparam byte_t COLOR_RAMP [16] = '{
        8'd0,   8'd0,   8'd0,   8'd88,
        8'd0,   8'd112, 8'd133, 8'd192,
        8'd60,  8'd150, 8'd166, 8'd212,
        8'd180, 8'd221, 8'd229, 8'd255
    };

endpackage

`default_nettype wire

//--- src/sync_dpram.sv
`timescale 1ns/10ps
`default_nettype none

module sync_dpram #(
    parameter int ADDR_W = 10,
    parameter int DATA_W = 8
) (
    input  wire                clk_20M,
    input  wire                we_i,
    input  wire [ADDR_W-1:0]   waddr_i,
    input  wire [DATA_W-1:0]   wdata_i,
    input  wire [ADDR_W-1:0]   raddr_i,
    output logic [DATA_W-1:0]  rdata_o
);

    // block rams come up cleared on the fpga
    logic [DATA_W-1:0] mem [2**ADDR_W] = '{default: '0};

    always_ff @(posedge clk_20M) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        // read port always registered
        rdata_o <= mem[raddr_i];
    end

endmodule

`default_nettype wire

//--- src/video_timing.sv
`timescale 1ns/10ps
`default_nettype none

module video_timing import mrdo_video_pkg::*; #(
    parameter int H_TOTAL   = 320,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 262,
    parameter int V_VISIBLE = 192
) (
    input  wire     clk_20M,
    input  wire     reset,
    output logic    pix_ce_o,
    output coord_t  h_o,
    output coord_t  v_o,
    output logic    hbl_o,
    output logic    vbl_o,
    output logic    hsync_o,
    output logic    vsync_o
);

    localparam int HC_W = $clog2(H_TOTAL);
    localparam int VC_W = $clog2(V_TOTAL);

    // blanking comes first in each line, then the 256 playfield pixels
    localparam int H_OFS    = H_TOTAL - LINE_W;
    localparam int HS_START = 16;
    localparam int HS_WIDTH = 24;
    localparam int VS_START = V_VISIBLE + 2;
    localparam int VS_WIDTH = 3;

    localparam logic [HC_W-1:0] H_LAST    = HC_W'(H_TOTAL - 1);
    localparam logic [HC_W-1:0] H_VIS_ON  = HC_W'(H_OFS);
    localparam logic [HC_W-1:0] H_VIS_OFF = HC_W'(H_OFS + H_VISIBLE);
    // sync lines up with the output pixels, less one for its own register
    localparam logic [HC_W-1:0] HS_ON     = HC_W'(HS_START + PIXEL_LEAD - 1);
    localparam logic [HC_W-1:0] HS_OFF    = HC_W'(HS_START + HS_WIDTH + PIXEL_LEAD - 1);
    localparam logic [VC_W-1:0] V_LAST    = VC_W'(V_TOTAL - 1);
    localparam logic [VC_W-1:0] V_VIS     = VC_W'(V_VISIBLE);
    localparam logic [VC_W-1:0] VS_ON     = VC_W'(VS_START);
    localparam logic [VC_W-1:0] VS_OFF    = VC_W'(VS_START + VS_WIDTH);

    logic [1:0]      ce_div;
    logic [HC_W-1:0] hc;
    logic [VC_W-1:0] vc;

    // 20 MHz / 4 = 5 MHz pixel rate
    always_ff @(posedge clk_20M) begin
        if (reset) begin
            ce_div   <= '0;
            pix_ce_o <= 1'b0;
        end else begin
            ce_div   <= ce_div + 2'd1;
            pix_ce_o <= (ce_div == 2'd3);
        end
    end

    always_ff @(posedge clk_20M) begin
        if (reset) begin
            hc      <= '0;
            vc      <= '0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
        end else if (pix_ce_o) begin
            if (hc == H_LAST) begin
                hc <= '0;
                vc <= (vc == V_LAST) ? '0 : vc + 1'b1;
            end else begin
                hc <= hc + 1'b1;
            end
            hsync_o <= (hc >= HS_ON) && (hc < HS_OFF);
            vsync_o <= (vc >= VS_ON) && (vc < VS_OFF);
        end
    end

    // playfield column wraps to 0 where the visible part starts
    assign h_o   = coord_t'(hc - H_VIS_ON);
    assign v_o   = coord_t'(vc);
    assign hbl_o = !((hc >= H_VIS_ON) && (hc < H_VIS_OFF));
    assign vbl_o = (vc >= V_VIS);

    a_hc_range: assert property (@(posedge clk_20M) disable iff (reset)
        hc < HC_W'(H_TOTAL));

endmodule

`default_nettype wire

//--- src/download_decode.sv
`timescale 1ns/10ps
`default_nettype none

module download_decode import mrdo_video_pkg::*; (
    input  wire             clk_20M,
    input  wire             reset,
    input  wire dl_addr_t   dl_addr_i,
    input  wire byte_t      dl_data_i,
    input  wire             dl_we_i,
    output logic [1:0]      map_we_o,
    output logic [1:0][1:0] plane_we_o,
    output logic [1:0]      scroll_we_o,
    output logic            pal_hi_we_o,
    output logic            pal_lo_we_o,
    output logic [11:0]     wr_addr_o,
    output byte_t           wr_data_o
);

    layer_e map_layer;
    layer_e plane_layer;
    layer_e scroll_layer;

    // bit 11 picks the map layer and bit 13 the plane layer
    assign map_layer    = layer_e'(dl_addr_i[11]);
    assign plane_layer  = layer_e'(dl_addr_i[13]);
    assign scroll_layer = layer_e'(dl_addr_i[0]);

    always_ff @(posedge clk_20M) begin
        if (reset) begin
            map_we_o    <= '0;
            plane_we_o  <= '0;
            scroll_we_o <= '0;
            pal_hi_we_o <= 1'b0;
            pal_lo_we_o <= 1'b0;
        end else begin
            map_we_o    <= '0;
            plane_we_o  <= '0;
            scroll_we_o <= '0;
            pal_hi_we_o <= 1'b0;
            pal_lo_we_o <= 1'b0;
            if (dl_we_i) begin
                if (dl_addr_i[15:12] == MAP_BASE[15:12]) begin
                    map_we_o[map_layer] <= 1'b1;
                end else if (dl_addr_i[15:14] == PLANE_BASE[15:14]) begin
                    plane_we_o[plane_layer][dl_addr_i[12]] <= 1'b1;
                end else if (dl_addr_i[15:5] == PAL_HI_BASE[15:5]) begin
                    pal_hi_we_o <= 1'b1;
                end else if (dl_addr_i[15:5] == PAL_LO_BASE[15:5]) begin
                    pal_lo_we_o <= 1'b1;
                end else if (dl_addr_i[15:1] == SCROLL_BASE[15:1]) begin
                    scroll_we_o[scroll_layer] <= 1'b1;
                end
            end
        end
    end

    // offset and data follow the strobes by the same cycle
    always_ff @(posedge clk_20M) begin
        wr_addr_o <= dl_addr_i[11:0];
        wr_data_o <= dl_data_i;
    end

    a_one_strobe: assert property (@(posedge clk_20M) disable iff (reset)
        $onehot0({map_we_o, plane_we_o, scroll_we_o, pal_hi_we_o, pal_lo_we_o}));

endmodule

`default_nettype wire

//--- src/tile_layer.sv
`timescale 1ns/10ps
`default_nettype none

module tile_layer import mrdo_video_pkg::*; (
    input  wire          clk_20M,
    input  wire          reset,
    input  wire          pix_ce_i,
    input  wire coord_t  h_i,
    input  wire coord_t  v_i,
    input  wire          map_we_i,
    input  wire [1:0]    plane_we_i,
    input  wire          scroll_we_i,
    input  wire [11:0]   wr_addr_i,
    input  wire byte_t   wr_data_i,
    output pix_t         pix_o,
    output byte_t        attr_o
);

    localparam int COL_W = $clog2(MAP_COLS);

    byte_t            scroll;
    coord_t           row;
    fetch_state_e     fetch_state;
    logic [COL_W-1:0] next_col;
    logic             attr_we;
    logic             code_we;
    map_addr_t        map_addr;
    bitmap_addr_t     bitmap_addr;
    byte_t            attr_rd;
    byte_t            code_rd;
    byte_t            plane0_rd;
    byte_t            plane1_rd;
    byte_t            plane0_sh;
    byte_t            plane1_sh;

    always_ff @(posedge clk_20M) begin
        if (reset) begin
            scroll <= '0;
        end else if (scroll_we_i) begin
            scroll <= wr_data_i;
        end
    end

    // scrolled line, tile row in the top 5 bits, line in tile in the low 3
    assign row      = v_i + scroll;
    assign next_col = h_i[7 -: COL_W] + 1'b1;

    // attributes in the lower 1k of the layer window, codes in the upper
    assign attr_we = map_we_i && !wr_addr_i[10];
    assign code_we = map_we_i && wr_addr_i[10];

    always_comb begin
        case (h_i[2:0])
            3'd5:    fetch_state = FETCH_MAP;
            3'd6:    fetch_state = FETCH_BITMAP;
            3'd7:    fetch_state = FETCH_LOAD;
            default: fetch_state = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk_20M) begin
        if (pix_ce_i) begin
            case (fetch_state)
                FETCH_MAP: begin
                    map_addr <= {row[7:3], next_col};
                end
                FETCH_BITMAP: begin
                    // attr bit 7 selects the upper tile bank
                    bitmap_addr <= {attr_rd[7], code_rd, row[2:0]};
                end
                default: begin
                end
            endcase

            if (fetch_state == FETCH_LOAD) begin
                plane0_sh <= plane0_rd;
                plane1_sh <= plane1_rd;
                attr_o    <= attr_rd;
            end else begin
                // lsb is the leftmost pixel of the tile
                plane0_sh <= plane0_sh >> 1;
                plane1_sh <= plane1_sh >> 1;
            end
        end
    end

    assign pix_o = {plane1_sh[0], plane0_sh[0]};

    sync_dpram #(.ADDR_W(10), .DATA_W(8)) attr_ram_inst (
        .clk_20M (clk_20M),
        .we_i    (attr_we),
        .waddr_i (wr_addr_i[9:0]),
        .wdata_i (wr_data_i),
        .raddr_i (map_addr),
        .rdata_o (attr_rd)
    );

    sync_dpram #(.ADDR_W(10), .DATA_W(8)) code_ram_inst (
        .clk_20M (clk_20M),
        .we_i    (code_we),
        .waddr_i (wr_addr_i[9:0]),
        .wdata_i (wr_data_i),
        .raddr_i (map_addr),
        .rdata_o (code_rd)
    );

    sync_dpram #(.ADDR_W(12), .DATA_W(8)) plane0_ram_inst (
        .clk_20M (clk_20M),
        .we_i    (plane_we_i[0]),
        .waddr_i (wr_addr_i),
        .wdata_i (wr_data_i),
        .raddr_i (bitmap_addr),
        .rdata_o (plane0_rd)
    );

    sync_dpram #(.ADDR_W(12), .DATA_W(8)) plane1_ram_inst (
        .clk_20M (clk_20M),
        .we_i    (plane_we_i[1]),
        .waddr_i (wr_addr_i),
        .wdata_i (wr_data_i),
        .raddr_i (bitmap_addr),
        .rdata_o (plane1_rd)
    );

endmodule

`default_nettype wire

//--- src/pixel_mixer.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_mixer import mrdo_video_pkg::*; (
    input  wire          clk_20M,
    input  wire          reset,
    input  wire          pix_ce_i,
    input  wire          hbl_i,
    input  wire          vbl_i,
    input  wire pix_t    bg_pix_i,
    input  wire byte_t   bg_attr_i,
    input  wire pix_t    fg_pix_i,
    input  wire byte_t   fg_attr_i,
    input  wire          pal_hi_we_i,
    input  wire          pal_lo_we_i,
    input  wire [11:0]   wr_addr_i,
    input  wire byte_t   wr_data_i,
    output chan_t        red_o,
    output chan_t        green_o,
    output chan_t        blue_o,
    output logic         hblank_o,
    output logic         vblank_o
);

    logic                  use_fg;
    logic                  use_bg;
    byte_t                 sel_attr;
    pix_t                  sel_pix;
    pal_addr_t             pal_hi_addr;
    pal_addr_t             pal_lo_addr;
    byte_t                 pal_hi_data;
    byte_t                 pal_lo_data;
    logic                  draw;
    logic [PIXEL_LEAD-1:0] hbl_pipe;
    logic [PIXEL_LEAD-1:0] vbl_pipe;
    logic                  out_blank;

    // two bits from each prom select one of 16 ladder levels
    function automatic chan_t ramp_level(input byte_t hi, input byte_t lo, input int c);
        byte_t level;
        level = COLOR_RAMP[{hi[2*c +: 2], lo[2*c +: 2]}];
        return level[7:4];
    endfunction

    // attr bit 6 forces the tile opaque
    assign use_fg = (fg_pix_i != 2'b00) || fg_attr_i[6];
    assign use_bg = (bg_pix_i != 2'b00) || bg_attr_i[6];

    always_comb begin
        if (use_fg) begin
            sel_attr = fg_attr_i;
            sel_pix  = fg_pix_i;
        end else begin
            sel_attr = bg_attr_i;
            sel_pix  = bg_pix_i;
        end
    end

    always_ff @(posedge clk_20M) begin
        if (pix_ce_i) begin
            pal_hi_addr <= {sel_attr[2:0], sel_pix};
            pal_lo_addr <= {sel_attr[5:3], sel_pix};
        end
    end

    // blank state for the pixel now in the colour stage
    assign out_blank = hbl_pipe[PIXEL_LEAD-2] || vbl_pipe[PIXEL_LEAD-2];

    always_ff @(posedge clk_20M) begin
        if (reset) begin
            draw     <= 1'b0;
            hbl_pipe <= '1;
            vbl_pipe <= '1;
            red_o    <= '0;
            green_o  <= '0;
            blue_o   <= '0;
        end else if (pix_ce_i) begin
            draw        <= use_fg || use_bg;
            hbl_pipe[0] <= hbl_i;
            vbl_pipe[0] <= vbl_i;
            for (int i = 1; i < PIXEL_LEAD; i++) begin
                hbl_pipe[i] <= hbl_pipe[i-1];
                vbl_pipe[i] <= vbl_pipe[i-1];
            end
            if (draw && !out_blank) begin
                red_o   <= ramp_level(pal_hi_data, pal_lo_data, 0);
                green_o <= ramp_level(pal_hi_data, pal_lo_data, 1);
                blue_o  <= ramp_level(pal_hi_data, pal_lo_data, 2);
            end else begin
                red_o   <= '0;
                green_o <= '0;
                blue_o  <= '0;
            end
        end
    end

    assign hblank_o = hbl_pipe[PIXEL_LEAD-1];
    assign vblank_o = vbl_pipe[PIXEL_LEAD-1];

    sync_dpram #(.ADDR_W(5), .DATA_W(8)) pal_hi_inst (
        .clk_20M (clk_20M),
        .we_i    (pal_hi_we_i),
        .waddr_i (wr_addr_i[4:0]),
        .wdata_i (wr_data_i),
        .raddr_i (pal_hi_addr),
        .rdata_o (pal_hi_data)
    );

    sync_dpram #(.ADDR_W(5), .DATA_W(8)) pal_lo_inst (
        .clk_20M (clk_20M),
        .we_i    (pal_lo_we_i),
        .waddr_i (wr_addr_i[4:0]),
        .wdata_i (wr_data_i),
        .raddr_i (pal_lo_addr),
        .rdata_o (pal_lo_data)
    );

    a_black_in_blank: assert property (@(posedge clk_20M) disable iff (reset)
        (hblank_o || vblank_o) |-> (red_o == '0 && green_o == '0 && blue_o == '0));

endmodule

`default_nettype wire

//--- src/mrdo_video_top.sv
`timescale 1ns/10ps
`default_nettype none

module mrdo_video_top import mrdo_video_pkg::*; #(
    parameter int H_TOTAL   = 320,
    parameter int H_VISIBLE = 256,
    parameter int V_TOTAL   = 262,
    parameter int V_VISIBLE = 192
) (
    input  wire            clk_20M,
    input  wire            reset,
    input  wire dl_addr_t  dl_addr_i,
    input  wire byte_t     dl_data_i,
    input  wire            dl_we_i,
    output chan_t          red_o,
    output chan_t          green_o,
    output chan_t          blue_o,
    output logic           hblank_o,
    output logic           vblank_o,
    output logic           hsync_o,
    output logic           vsync_o,
    output logic           pix_ce_o
);

    logic            pix_ce;
    coord_t          h;
    coord_t          v;
    logic            hbl;
    logic            vbl;
    logic [1:0]      map_we;
    logic [1:0][1:0] plane_we;
    logic [1:0]      scroll_we;
    logic            pal_hi_we;
    logic            pal_lo_we;
    logic [11:0]     wr_addr;
    byte_t           wr_data;
    pix_t            layer_pix [2];
    byte_t           layer_attr [2];

    assign pix_ce_o = pix_ce;

    video_timing #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) video_timing_inst (
        .clk_20M  (clk_20M),
        .reset    (reset),
        .pix_ce_o (pix_ce),
        .h_o      (h),
        .v_o      (v),
        .hbl_o    (hbl),
        .vbl_o    (vbl),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    download_decode download_decode_inst (
        .clk_20M     (clk_20M),
        .reset       (reset),
        .dl_addr_i   (dl_addr_i),
        .dl_data_i   (dl_data_i),
        .dl_we_i     (dl_we_i),
        .map_we_o    (map_we),
        .plane_we_o  (plane_we),
        .scroll_we_o (scroll_we),
        .pal_hi_we_o (pal_hi_we),
        .pal_lo_we_o (pal_lo_we),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    // background and foreground are the same hardware
    for (genvar g = LAYER_BG; g <= LAYER_FG; g++) begin : g_layer
        tile_layer tile_layer_inst (
            .clk_20M     (clk_20M),
            .reset       (reset),
            .pix_ce_i    (pix_ce),
            .h_i         (h),
            .v_i         (v),
            .map_we_i    (map_we[g]),
            .plane_we_i  (plane_we[g]),
            .scroll_we_i (scroll_we[g]),
            .wr_addr_i   (wr_addr),
            .wr_data_i   (wr_data),
            .pix_o       (layer_pix[g]),
            .attr_o      (layer_attr[g])
        );
    end

    pixel_mixer pixel_mixer_inst (
        .clk_20M     (clk_20M),
        .reset       (reset),
        .pix_ce_i    (pix_ce),
        .hbl_i       (hbl),
        .vbl_i       (vbl),
        .bg_pix_i    (layer_pix[LAYER_BG]),
        .bg_attr_i   (layer_attr[LAYER_BG]),
        .fg_pix_i    (layer_pix[LAYER_FG]),
        .fg_attr_i   (layer_attr[LAYER_FG]),
        .pal_hi_we_i (pal_hi_we),
        .pal_lo_we_i (pal_lo_we),
        .wr_addr_i   (wr_addr),
        .wr_data_i   (wr_data),
        .red_o       (red_o),
        .green_o     (green_o),
        .blue_o      (blue_o),
        .hblank_o    (hblank_o),
        .vblank_o    (vblank_o)
    );

endmodule

`default_nettype wire

//--- tb/mrdo_video_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mrdo_video_tb import mrdo_video_pkg::*; ();

    localparam int H_TOTAL   = 320;
    localparam int H_VISIBLE = 256;
    localparam int V_TOTAL   = 40;
    localparam int V_VISIBLE = 32;

    // five frames of cleared memories, fg only, both layers, scrolled bg and new palettes
    localparam int NUM_FRAMES     = 5;
    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL * 4;
    localparam int TIMEOUT_CYCLES = (NUM_FRAMES + 1) * FRAME_CYCLES;
    // stop loading some pixels before the first fetch of the next frame
    localparam int LOAD_PIX       = (V_TOTAL - V_VISIBLE) * H_TOTAL - 16;

    logic     clk_20M;
    logic     reset;
    dl_addr_t dl_addr;
    byte_t    dl_data;
    logic     dl_we;
    chan_t    red;
    chan_t    green;
    chan_t    blue;
    logic     hblank;
    logic     vblank;
    logic     hsync;
    logic     vsync;
    logic     pix_ce;

    // shadow copies of everything written through the download port
    byte_t attr_sh   [2][1024]    = '{default: '0};
    byte_t code_sh   [2][1024]    = '{default: '0};
    byte_t plane_sh  [2][2][4096] = '{default: '0};
    byte_t pal_hi_sh [32]         = '{default: '0};
    byte_t pal_lo_sh [32]         = '{default: '0};
    byte_t scroll_sh [2]          = '{default: '0};

    int          cycle_cnt    = 0;
    int          vbl_pix      = 0;
    logic        load_ok;
    int          frames_done  = 0;
    int          error_count  = 0;
    int          x            = 0;
    int          y            = 0;
    logic        visible;
    logic        prev_visible = 1'b0;
    logic        prev_vblank  = 1'b1;
    int          hsync_cnt    = 0;
    int          vsync_cnt    = 0;
    logic        prev_hsync   = 1'b0;
    logic        prev_vsync   = 1'b0;
    logic [11:0] exp_rgb;

    mrdo_video_top #(
        .H_TOTAL   (H_TOTAL),
        .H_VISIBLE (H_VISIBLE),
        .V_TOTAL   (V_TOTAL),
        .V_VISIBLE (V_VISIBLE)
    ) mrdo_video_top_inst (
        .clk_20M   (clk_20M),
        .reset     (reset),
        .dl_addr_i (dl_addr),
        .dl_data_i (dl_data),
        .dl_we_i   (dl_we),
        .red_o     (red),
        .green_o   (green),
        .blue_o    (blue),
        .hblank_o  (hblank),
        .vblank_o  (vblank),
        .hsync_o   (hsync),
        .vsync_o   (vsync),
        .pix_ce_o  (pix_ce)
    );

    initial begin
        clk_20M = 1'b0;
        forever #25 clk_20M = ~clk_20M;
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_rgb(input string what, input chan_t got_r, input chan_t got_g,
                             input chan_t got_b, input chan_t exp_r, input chan_t exp_g,
                             input chan_t exp_b);
        if (got_r !== exp_r || got_g !== exp_g || got_b !== exp_b) begin
            $display("error at %0t: %s rgb %h %h %h, expected %h %h %h", $time, what,
                     got_r, got_g, got_b, exp_r, exp_g, exp_b);
            error_count++;
            abort_run();
        end
    endtask

    task automatic check_count(input string what, input coord_t got, input coord_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
            abort_run();
        end
    endtask

    // expected gun levels for screen pixel (px, py) packed as red, green and blue
    function automatic logic [11:0] ref_rgb(input int px, input int py);
        byte_t        attr [2];
        pix_t         pix [2];
        logic         opaque [2];
        byte_t        row;
        byte_t        code;
        map_addr_t    tile;
        bitmap_addr_t baddr;
        logic [2:0]   col;
        int           sel;
        byte_t        hi;
        byte_t        lo;
        byte_t        level;
        logic [11:0]  rgb;
        col = 3'(px);
        for (int l = 0; l < 2; l++) begin
            row       = byte_t'(py + int'(scroll_sh[l]));
            tile      = {row[7:3], 5'(px / 8)};
            attr[l]   = attr_sh[l][tile];
            code      = code_sh[l][tile];
            baddr     = {attr[l][7], code, row[2:0]};
            pix[l]    = {plane_sh[l][1][baddr][col], plane_sh[l][0][baddr][col]};
            opaque[l] = (pix[l] != 2'b00) || attr[l][6];
        end
        // foreground wins, then background, else the pixel stays dark
        if (opaque[int'(LAYER_FG)]) begin
            sel = int'(LAYER_FG);
        end else if (opaque[int'(LAYER_BG)]) begin
            sel = int'(LAYER_BG);
        end else begin
            return 12'h000;
        end
        hi = pal_hi_sh[{attr[sel][2:0], pix[sel]}];
        lo = pal_lo_sh[{attr[sel][5:3], pix[sel]}];
        for (int c = 0; c < 3; c++) begin
            level = COLOR_RAMP[{hi[2*c +: 2], lo[2*c +: 2]}];
            rgb[11 - 4*c -: 4] = level[7:4];
        end
        return rgb;
    endfunction

    // one write per clock, held back while outside the load window
    task automatic download_byte(input dl_addr_t addr, input byte_t data);
        @(posedge clk_20M);
        while (!load_ok) begin
            dl_we <= 1'b0;
            @(posedge clk_20M);
        end
        dl_addr <= addr;
        dl_data <= data;
        dl_we   <= 1'b1;
    endtask

    task automatic release_port();
        @(posedge clk_20M);
        dl_we <= 1'b0;
    endtask

    task automatic write_map(input int layer, input logic is_code, input map_addr_t idx,
                             input byte_t data);
        download_byte(MAP_BASE + dl_addr_t'(layer * 'h800)
                      + (is_code ? 16'h0400 : 16'h0000) + dl_addr_t'(idx), data);
        if (is_code) begin
            code_sh[layer][idx] = data;
        end else begin
            attr_sh[layer][idx] = data;
        end
    endtask

    task automatic write_plane(input int layer, input int plane, input bitmap_addr_t addr,
                               input byte_t data);
        download_byte(PLANE_BASE + dl_addr_t'((layer * 2 + plane) * 'h1000)
                      + dl_addr_t'(addr), data);
        plane_sh[layer][plane][addr] = data;
    endtask

    task automatic write_palette(input logic is_lo, input pal_addr_t idx, input byte_t data);
        download_byte((is_lo ? PAL_LO_BASE : PAL_HI_BASE) + dl_addr_t'(idx), data);
        if (is_lo) begin
            pal_lo_sh[idx] = data;
        end else begin
            pal_hi_sh[idx] = data;
        end
    endtask

    task automatic write_scroll(input int layer, input byte_t data);
        download_byte(SCROLL_BASE + dl_addr_t'(layer), data);
        scroll_sh[layer] = data;
    endtask

    // random map rows, plus the bitmap rows that those tiles point at
    task automatic load_layer(input int layer, input int rows);
        byte_t attr;
        byte_t code;
        for (int i = 0; i < rows * 32; i++) begin
            attr = byte_t'($urandom);
            code = byte_t'($urandom);
            write_map(layer, 1'b0, map_addr_t'(i), attr);
            write_map(layer, 1'b1, map_addr_t'(i), code);
            for (int r = 0; r < 8; r++) begin
                write_plane(layer, 0, {attr[7], code, 3'(r)}, byte_t'($urandom));
                write_plane(layer, 1, {attr[7], code, 3'(r)}, byte_t'($urandom));
            end
        end
    endtask

    task automatic load_palettes();
        for (int i = 0; i < 32; i++) begin
            write_palette(1'b0, pal_addr_t'(i), byte_t'($urandom));
            write_palette(1'b1, pal_addr_t'(i), byte_t'($urandom));
        end
    endtask

    always @(posedge clk_20M) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d clock cycles",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // pixels spent in the current vblank
    always @(posedge clk_20M) begin
        if (reset || !vblank) begin
            vbl_pix <= 0;
        end else if (pix_ce) begin
            vbl_pix <= vbl_pix + 1;
        end
    end

    assign load_ok = !reset && vblank && (vbl_pix < LOAD_PIX);

    // outputs are steady in the middle of the pix_ce cycle
    always @(negedge clk_20M) begin
        if (!reset && pix_ce) begin
            visible = !hblank && !vblank;
            if (hsync && !hblank) begin
                $display("error at %0t: hsync active outside horizontal blanking", $time);
                error_count++;
                abort_run();
            end
            if (vsync && !vblank) begin
                $display("error at %0t: vsync active outside vertical blanking", $time);
                error_count++;
                abort_run();
            end
            if (hsync && !prev_hsync) begin
                hsync_cnt++;
            end
            if (vsync && !prev_vsync) begin
                vsync_cnt++;
            end
            if (visible) begin
                if (x >= H_VISIBLE || y >= V_VISIBLE) begin
                    $display("more visible pixels than the raster holds, at line %0d", y);
                    abort_run();
                end
                exp_rgb = ref_rgb(x, y);
                check_rgb($sformatf("pixel (%0d, %0d)", x, y), red, green, blue,
                          exp_rgb[11:8], exp_rgb[7:4], exp_rgb[3:0]);
                x++;
            end else begin
                check_rgb("blanked output", red, green, blue, '0, '0, '0);
                if (prev_visible) begin
                    check_count("last visible column", coord_t'(x - 1),
                                coord_t'(H_VISIBLE - 1));
                    x = 0;
                    y++;
                end
            end
            if (vblank && !prev_vblank) begin
                check_count("visible lines in frame", coord_t'(y), coord_t'(V_VISIBLE));
                // the frame after reset holds only the visible lines and no vsync
                if (frames_done > 0) begin
                    check_count("hsync pulses in frame", coord_t'(hsync_cnt),
                                coord_t'(V_TOTAL));
                    check_count("vsync pulses in frame", coord_t'(vsync_cnt),
                                coord_t'(1));
                end
                hsync_cnt = 0;
                vsync_cnt = 0;
                y = 0;
                frames_done++;
            end
            prev_visible = visible;
            prev_vblank  = vblank;
            prev_hsync   = hsync;
            prev_vsync   = vsync;
        end
    end

    initial begin
        byte_t bg_scroll;
        void'($urandom(32'h2f68));
        reset   = 1'b1;
        dl_addr = '0;
        dl_data = '0;
        dl_we   = 1'b0;
        repeat (4) @(posedge clk_20M);
        reset <= 1'b0;

        // frame 0 shows cleared memories
        wait (frames_done == 1);
        load_layer(int'(LAYER_FG), 4);
        load_palettes();
        release_port();

        wait (frames_done == 2);
        load_layer(int'(LAYER_BG), 8);
        release_port();

        // stays inside the eight loaded background rows
        wait (frames_done == 3);
        bg_scroll = byte_t'($urandom % 31 + 1);
        write_scroll(int'(LAYER_BG), bg_scroll);
        release_port();

        wait (frames_done == 4);
        load_palettes();
        release_port();

        wait (frames_done == NUM_FRAMES);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d checks failed", error_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
src/mrdo_video_pkg.sv
src/sync_dpram.sv
src/video_timing.sv
src/download_decode.sv
src/tile_layer.sv
src/pixel_mixer.sv
src/mrdo_video_top.sv
tb/mrdo_video_tb.sv

//--- Makefile
# Verilator simulation of the playfield video path

VERILATOR ?= verilator
TOP       ?= mrdo_video_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# a failing run ends in $fatal, so the binary exits non-zero
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
